//--- ads816x_adc_ctrl.f
+incdir+rtl
rtl/ads816x_pkg.sv
rtl/cmd_decoder.sv
rtl/acq_sequencer.sv
rtl/spi_frame_engine.sv
rtl/sample_packer.sv
rtl/ads816x_adc_ctrl.sv
verification/tb_clock_gen.sv
verification/tb_checker.sv
verification/tb_ads816x_adc_ctrl.sv

//--- verification/tb_ads816x_adc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "ads816x_params.svh"

module tb_ads816x_adc_ctrl
  import ads816x_pkg::*;
();

  localparam int N_ROWS        = 8;
  localparam int FRAME_CYCLES  = `ADS_CS_HIGH_CYCLES + `ADS_FRAME_BITS;
  localparam int SETTLE_CYCLES = `ADS_RD_FRAMES * FRAME_CYCLES; // One whole read
  localparam int WATCHDOG_NS   = N_ROWS * `ADS_RD_FRAMES * FRAME_CYCLES * 8 * 4;

  localparam logic [1:0] KIND_NO_OP   = 2'd0; // Command kinds in bits 31:30
  localparam logic [1:0] KIND_ADC_RD  = 2'd1;
  localparam logic [1:0] KIND_SET_ORD = 2'd2;
  localparam logic [1:0] KIND_CANCEL  = 2'd3;
  localparam int TRIG_NONE = 0;
  localparam int TRIG_ON_WAIT = 1; // Pulse once waiting_for_trig is high
  localparam int TRIG_IN_IDLE = 2; // Pulse with nothing waiting

  localparam order_t IDENT_ORD = {3'd7, 3'd6, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0};
  localparam order_t PERM_ORD  = {3'd4, 3'd2, 3'd6, 3'd1, 3'd7, 3'd0, 3'd5, 3'd3};

  logic      clk, resetn;
  cmd_word_t cmd_word, data_word;
  logic      cmd_buf_empty, cmd_word_rd_en, data_word_wr_en, data_buf_full;
  logic      trigger, waiting_for_trig, unexp_trig, cmd_buf_underflow, data_buf_overflow;
  logic      n_cs, mosi, miso;

  // Stimulus table, one entry per test
  string      name_tab[N_ROWS];
  cmd_word_t  cmd_tab[N_ROWS][4];
  int         n_cmd_tab[N_ROWS];
  int         n_early_tab[N_ROWS]; // Commands queued at the start, the rest after a flag
  int         trig_tab[N_ROWS];
  logic       full_tab[N_ROWS];
  err_flags_t flags_tab[N_ROWS];
  order_t     order_tab[N_ROWS];   // Slot order behind the expected words
  int         n_words_tab[N_ROWS];
  int         pops_tab[N_ROWS];
  logic       quiet_tab[N_ROWS];
  int         n_rows = 0;

  cmd_word_t  cmd_q[$];            // FWFT command buffer contents
  logic [15:0] req_sr = '0;
  sample_t    tx_word = '0;
  int         bit_no = 0;

  tb_clock_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(10)) clk_gen_i (.clk(clk), .resetn(resetn));

  ads816x_adc_ctrl dut_i (
    .clk(clk), .resetn(resetn), .cmd_word(cmd_word), .cmd_buf_empty(cmd_buf_empty),
    .cmd_word_rd_en(cmd_word_rd_en), .data_word(data_word), .data_word_wr_en(data_word_wr_en),
    .data_buf_full(data_buf_full), .trigger(trigger), .waiting_for_trig(waiting_for_trig),
    .unexp_trig(unexp_trig), .cmd_buf_underflow(cmd_buf_underflow),
    .data_buf_overflow(data_buf_overflow), .n_cs(n_cs), .mosi(mosi), .miso(miso)
  );

  tb_checker checker_i (
    .clk(clk), .cmd_word_rd_en(cmd_word_rd_en), .data_word_wr_en(data_word_wr_en),
    .data_word(data_word), .waiting_for_trig(waiting_for_trig), .unexp_trig(unexp_trig),
    .cmd_buf_underflow(cmd_buf_underflow), .data_buf_overflow(data_buf_overflow), .n_cs(n_cs)
  );

  function automatic cmd_word_t make_cmd(input logic [1:0] kind, input logic trig,
                                         input logic cont, input logic [25:0] delay);
    return {kind, trig, cont, 2'b00, delay};
  endfunction

  function automatic sample_t adc_value(input chan_t ch);
    return {ch, 13'h1A5}; // Channel on top, fixed pattern below
  endfunction

  function automatic cmd_word_t pair_word(input order_t ord, input int k);
    return {adc_value(ord[2*k+1]), adc_value(ord[2*k])}; // Second result high
  endfunction

  task automatic add_row(input string name, input cmd_word_t c0, c1, c2, c3,
                         input int n_cmd, n_early, trig, input logic full,
                         input err_flags_t flags, input order_t ord,
                         input int n_words, pops, input logic quiet);
    name_tab[n_rows]    = name;
    cmd_tab[n_rows][0]  = c0;
    cmd_tab[n_rows][1]  = c1;
    cmd_tab[n_rows][2]  = c2;
    cmd_tab[n_rows][3]  = c3;
    n_cmd_tab[n_rows]   = n_cmd;
    n_early_tab[n_rows] = n_early;
    trig_tab[n_rows]    = trig;
    full_tab[n_rows]    = full;
    flags_tab[n_rows]   = flags;
    order_tab[n_rows]   = ord;
    n_words_tab[n_rows] = n_words;
    pops_tab[n_rows]    = pops;
    quiet_tab[n_rows]   = quiet;
    n_rows++;
  endtask

  task automatic fill_table();
    cmd_word_t rd;
    cmd_word_t wait_trig;
    cmd_word_t cancel;
    rd        = make_cmd(KIND_ADC_RD, 1'b0, 1'b0, 26'd0);
    wait_trig = make_cmd(KIND_NO_OP, 1'b1, 1'b0, 26'd0);
    cancel    = make_cmd(KIND_CANCEL, 1'b0, 1'b0, 26'd0);
    add_row("default_order", rd, '0, '0, '0, 1, 1, TRIG_NONE, 0, 3'b000, IDENT_ORD, 4, 1, 0);
    add_row("custom_order", {KIND_SET_ORD, 6'd0, PERM_ORD}, rd, '0, '0,
            2, 2, TRIG_NONE, 0, 3'b000, PERM_ORD, 4, 2, 0);
    add_row("trigger_wait", make_cmd(KIND_NO_OP, 1'b1, 1'b1, 26'd0), rd, '0, '0,
            2, 2, TRIG_ON_WAIT, 0, 3'b000, IDENT_ORD, 4, 2, 0);
    add_row("cancel_wait", wait_trig, cancel, rd, '0, 3, 3, TRIG_NONE, 0, 3'b000, IDENT_ORD, 4, 3, 0);
    add_row("cancel_delay", make_cmd(KIND_NO_OP, 1'b0, 1'b0, 26'h3FF_FFFF), cancel, rd, '0,
            3, 3, TRIG_NONE, 0, 3'b000, IDENT_ORD, 4, 3, 0);
    add_row("unexp_trigger", rd, '0, '0, '0, 1, 0, TRIG_IN_IDLE, 0, 3'b100, IDENT_ORD, 0, 0, 1);
    add_row("cmd_underflow", make_cmd(KIND_NO_OP, 1'b0, 1'b1, 26'd20), rd, '0, '0,
            2, 1, TRIG_NONE, 0, 3'b010, IDENT_ORD, 0, 1, 1);
    add_row("data_overflow", rd, '0, '0, '0, 1, 1, TRIG_NONE, 1, 3'b001, IDENT_ORD, 0, 1, 0);
  endtask

  //////////////////////////////
  // Command buffer and ADC model
  //////////////////////////////
  task automatic push_cmds(input int r, input int first, input int last);
    @(negedge clk); // Away from the pop edge
    for (int i = first; i < last; i++) cmd_q.push_back(cmd_tab[r][i]);
  endtask

  always @(posedge clk) begin
    if (cmd_word_rd_en && cmd_q.size() > 0) void'(cmd_q.pop_front());
    #1;
    cmd_buf_empty = cmd_q.size() == 0;
    cmd_word      = (cmd_q.size() > 0) ? cmd_q[0] : '0; // Head shows through
  end

  // Shifts the request in while n_cs is low; its result goes out in the next frame
  always @(posedge clk) begin
    if (!resetn) begin
      bit_no = 0;
    end else if (!n_cs) begin
      req_sr = {req_sr[14:0], mosi};
      bit_no = bit_no + 1;
      if (bit_no == `ADS_FRAME_BITS) begin
        checker_i.compare("request header", 32'(2'b10), 32'(req_sr[15:14]));
        tx_word = adc_value(req_sr[13:11]);
        bit_no  = 0;
      end
    end
    #1 miso = tx_word[15 - bit_no]; // MSB first
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  task automatic run_row(input int r);
    @(negedge clk);
    cmd_q.delete();
    @(posedge clk);
    #1;
    data_buf_full = full_tab[r];
    trigger       = 1'b0;
    clk_gen_i.apply_reset();
    checker_i.begin_row(name_tab[r], flags_tab[r], pops_tab[r], quiet_tab[r]);
    for (int k = 0; k < n_words_tab[r]; k++) checker_i.expect_word(pair_word(order_tab[r], k));
    push_cmds(r, 0, n_early_tab[r]);
    if (trig_tab[r] != TRIG_NONE) begin
      @(posedge clk);
      if (trig_tab[r] == TRIG_ON_WAIT) begin
        while (!waiting_for_trig) @(posedge clk);
      end
      #1 trigger = 1'b1;
      @(posedge clk);
      #1 trigger = 1'b0;
    end
    if (flags_tab[r] != '0) begin
      while ({unexp_trig, cmd_buf_underflow, data_buf_overflow} == 3'b000) @(posedge clk);
    end else begin
      while (checker_i.words_seen < n_words_tab[r]) @(posedge clk);
    end
    push_cmds(r, n_early_tab[r], n_cmd_tab[r]); // Must stay unpopped after a halt
    repeat (SETTLE_CYCLES) @(posedge clk);
    checker_i.end_row();
  endtask

  initial begin
    cmd_word      = '0;
    cmd_buf_empty = 1'b1;
    trigger       = 1'b0;
    data_buf_full = 1'b0;
    miso          = 1'b0;
    fill_table();
    for (int r = 0; r < n_rows; r++) run_row(r);
    $display("Summary: %0d tests, %0d checks, %0d errors", n_rows, checker_i.check_count,
             checker_i.error_count);
    if (checker_i.error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not complete within %0d ns", WATCHDOG_NS);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

// Watches the DUT ports and compares them with the row's expectations
module tb_checker
  import ads816x_pkg::*;
(
  input wire            clk,
  input wire            cmd_word_rd_en,
  input wire            data_word_wr_en,
  input wire cmd_word_t data_word,
  input wire            waiting_for_trig,
  input wire            unexp_trig,
  input wire            cmd_buf_underflow,
  input wire            data_buf_overflow,
  input wire            n_cs
);

  string      row_name;
  logic       active = 1'b0;  // Row in progress
  cmd_word_t  exp_words[$];   // Words still to come
  err_flags_t exp_flags;
  err_flags_t flags;
  int         exp_total;
  int         exp_pops;
  bit         quiet;          // n_cs must never fall
  int         words_seen;
  int         pops_seen;
  int         cs_low_seen;
  int         check_count = 0;
  int         error_count = 0;

  assign flags = {unexp_trig, cmd_buf_underflow, data_buf_overflow};

  task automatic compare(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("[ERROR] %s %s expected %h actual %h", row_name, what, expected, actual);
    end
  endtask

  //////////////////////////////
  // Row control
  //////////////////////////////
  task automatic begin_row(input string name, input err_flags_t flags_exp,
                           input int pops_exp, input bit quiet_bus);
    row_name    = name;
    exp_flags   = flags_exp;
    exp_pops    = pops_exp;
    quiet       = quiet_bus;
    exp_total   = 0;
    words_seen  = 0;
    pops_seen   = 0;
    cs_low_seen = 0;
    exp_words.delete();
    active      = 1'b1;
  endtask

  task automatic expect_word(input cmd_word_t w);
    exp_words.push_back(w);
    exp_total++;
  endtask

  task automatic end_row();
    active = 1'b0;
    compare("flags", exp_flags, flags);
    compare("commands popped", exp_pops, pops_seen);
    compare("data word count", exp_total, words_seen);
    compare("waiting_for_trig at end", 0, waiting_for_trig);
    compare("n_cs at end", 1, n_cs); // Bus idle
    if (quiet) compare("n_cs low cycles", 0, cs_low_seen);
  endtask

  //////////////////////////////
  // Port monitor
  //////////////////////////////
  always @(posedge clk) begin
    if (active) begin
      if (cmd_word_rd_en) pops_seen++;
      if (!n_cs) cs_low_seen++;
      if (data_word_wr_en) begin
        if (exp_words.size() == 0) begin
          error_count++;
          $display("%s wrote data word %h when no more words were due", row_name, data_word);
        end else begin
          compare($sformatf("data word %0d", words_seen), exp_words.pop_front(), data_word);
        end
        words_seen++;
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running clock plus a reset pulse on request
module tb_clock_gen #(
  parameter real PERIOD_NS    = 8.0,
  parameter int  RESET_CYCLES = 10
) (
  output logic clk,
  output logic resetn
);

  initial begin
    clk    = 1'b0;
    resetn = 1'b0; // Held low until the first reset completes
  end

  always #(PERIOD_NS / 2.0) clk = ~clk;

  // Synchronous reset, released 1 ns after an edge
  task automatic apply_reset();
    @(posedge clk);
    #1 resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 resetn = 1'b1;
  endtask

endmodule

`default_nettype wire

//--- rtl/ads816x_adc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// ADS816x on-the-fly controller top level
module ads816x_adc_ctrl
  import ads816x_pkg::*;
(
  input  wire            clk,
  input  wire            resetn,
  input  wire cmd_word_t cmd_word,          // FWFT head
  input  wire            cmd_buf_empty,
  output logic           cmd_word_rd_en,
  output cmd_word_t      data_word,
  output logic           data_word_wr_en,
  input  wire            data_buf_full,
  input  wire            trigger,
  output logic           waiting_for_trig,
  output logic           unexp_trig,
  output logic           cmd_buf_underflow,
  output logic           data_buf_overflow,
  output logic           n_cs,
  output logic           mosi,
  input  wire            miso
);

  cmd_t       cmd;
  order_t     order;
  frame_req_t frame_req;
  err_flags_t err_flags;
  sample_t    sample;
  logic       halt;
  logic       frame_done;
  logic       sample_valid;
  logic       overflow;

  //////////////////////////////
  // Input side
  //////////////////////////////
  cmd_decoder cmd_decoder_i (
    .clk      (clk),
    .resetn   (resetn),
    .cmd_word (cmd_word),
    .take     (cmd_word_rd_en),
    .cmd      (cmd),
    .order    (order)
  );

  //////////////////////////////
  // Processing
  //////////////////////////////
  acq_sequencer acq_sequencer_i (
    .clk              (clk),
    .resetn           (resetn),
    .cmd_buf_empty    (cmd_buf_empty),
    .trigger          (trigger),
    .frame_done       (frame_done),
    .overflow         (overflow),
    .cmd              (cmd),
    .order            (order),
    .cmd_word_rd_en   (cmd_word_rd_en),
    .waiting_for_trig (waiting_for_trig),
    .halt             (halt),
    .frame_req        (frame_req),
    .err_flags        (err_flags)
  );

  spi_frame_engine spi_frame_engine_i (
    .clk          (clk),
    .resetn       (resetn),
    .halt         (halt),
    .frame_req    (frame_req),
    .miso         (miso),
    .n_cs         (n_cs),
    .mosi         (mosi),
    .frame_done   (frame_done),
    .sample_valid (sample_valid),
    .sample       (sample)
  );

  //////////////////////////////
  // Output side
  //////////////////////////////
  sample_packer sample_packer_i (
    .clk             (clk),
    .resetn          (resetn),
    .halt            (halt),
    .sample_valid    (sample_valid),
    .data_buf_full   (data_buf_full),
    .sample          (sample),
    .data_word_wr_en (data_word_wr_en),
    .overflow        (overflow),
    .data_word       (data_word)
  );

  // Sticky flags out to the ports
  assign unexp_trig        = err_flags.unexp_trig;
  assign cmd_buf_underflow = err_flags.cmd_buf_underflow;
  assign data_buf_overflow = err_flags.data_buf_overflow;

endmodule

`default_nettype wire

//--- rtl/sample_packer.sv
`timescale 1ns/1ps
`default_nettype none

// Pairs 16-bit results into 32-bit data buffer words
module sample_packer
  import ads816x_pkg::*;
(
  input  wire          clk,
  input  wire          resetn,
  input  wire          halt,
  input  wire          sample_valid,
  input  wire          data_buf_full,
  input  wire sample_t sample,
  output logic         data_word_wr_en,
  output logic         overflow,       // Write attempt against a full buffer
  output cmd_word_t    data_word
);

  sample_t first_q;    // First result of the pair
  logic    stored;     // first_q holds a result
  logic    pair_ready; // Second result arriving

  assign pair_ready = sample_valid && stored;

  //////////////////////////////
  // Pair control
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      stored          <= 1'b0;
      data_word_wr_en <= 1'b0;
      overflow        <= 1'b0;
    end else begin
      data_word_wr_en <= pair_ready && !data_buf_full;
      overflow        <= pair_ready && data_buf_full; // Write dropped
      if (sample_valid) stored <= !stored;
    end
  end

  // Second result high and first result low
  always_ff @(posedge clk) begin
    if (sample_valid && !stored) first_q <= sample;
    if (pair_ready) data_word <= {sample, first_q};
  end

endmodule

`default_nettype wire

//--- rtl/spi_frame_engine.sv
`timescale 1ns/1ps
`default_nettype none
`include "ads816x_params.svh"

// One on-the-fly SPI frame per start pulse. n_cs high phase then 16 clocked bits
module spi_frame_engine
  import ads816x_pkg::*;
(
  input  wire             clk,
  input  wire             resetn,
  input  wire             halt,
  input  wire frame_req_t frame_req,
  input  wire             miso,         // Sampled on clk
  output logic            n_cs,
  output logic            mosi,
  output logic            frame_done,   // Cycle in which n_cs returns high
  output logic            sample_valid, // One cycle after frame_done
  output sample_t         sample
);

  localparam int CS_W    = $clog2(`ADS_CS_HIGH_CYCLES + 1);
  localparam int BIT_W   = $clog2(`ADS_FRAME_BITS + 1);
  localparam int REQ_PAD = `ADS_FRAME_BITS - 2 - $bits(chan_t); // Zeros after the channel

  localparam logic [CS_W-1:0]  CS_LOAD  = CS_W'(`ADS_CS_HIGH_CYCLES);
  localparam logic [BIT_W-1:0] BIT_LOAD = BIT_W'(`ADS_FRAME_BITS);

  logic [CS_W-1:0]            cs_cnt;    // n_cs high timer
  logic [BIT_W-1:0]           bit_cnt;   // Bits left in the low phase
  logic                       capture_q; // This frame returns a result
  logic [`ADS_FRAME_BITS-1:0] mosi_sr;
  sample_t                    miso_sr;
  logic                       cs_last;   // Final high cycle
  logic                       bit_last;  // Final low cycle

  assign cs_last  = cs_cnt == CS_W'(1);
  assign bit_last = bit_cnt == BIT_W'(1);

  //////////////////////////////
  // Chip select timing
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      cs_cnt    <= '0;
      capture_q <= 1'b0;
    end else if (frame_req.start) begin
      cs_cnt    <= CS_LOAD;
      capture_q <= frame_req.capture;
    end else if (cs_cnt != '0) begin
      cs_cnt <= cs_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      n_cs    <= 1'b1; // Idle high
      bit_cnt <= '0;
    end else if (cs_last) begin
      n_cs    <= 1'b0;
      bit_cnt <= BIT_LOAD;
    end else if (bit_cnt != '0) begin
      bit_cnt <= bit_cnt - 1'b1;
      if (bit_last) n_cs <= 1'b1;
    end
  end

  //////////////////////////////
  // Data shifting
  //////////////////////////////
  // Request is "10", channel, zeros, sent MSB first
  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      mosi_sr <= '0;
    end else if (cs_last) begin
      mosi_sr <= {2'b10, frame_req.chan, {REQ_PAD{1'b0}}};
    end else if (bit_cnt != '0) begin
      mosi_sr <= {mosi_sr[`ADS_FRAME_BITS-2:0], 1'b0};
    end
  end

  assign mosi = mosi_sr[`ADS_FRAME_BITS-1];

  // MISO enters MSB first during the low phase
  always_ff @(posedge clk) begin
    if (bit_cnt != '0) miso_sr <= {miso_sr[$bits(sample_t)-2:0], miso};
  end

  assign sample = miso_sr; // Held until the next low phase

  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      frame_done   <= 1'b0;
      sample_valid <= 1'b0;
    end else begin
      frame_done   <= bit_last;
      sample_valid <= frame_done && capture_q;
    end
  end

endmodule

`default_nettype wire

//--- rtl/acq_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "ads816x_params.svh"

// Command FSM, delay timer, frame indexing and sticky error flags
module acq_sequencer
  import ads816x_pkg::*;
(
  input  wire         clk,
  input  wire         resetn,
  input  wire         cmd_buf_empty,
  input  wire         trigger,
  input  wire         frame_done,
  input  wire         overflow,      // From the packer
  input  wire cmd_t   cmd,
  input  wire order_t order,
  output logic        cmd_word_rd_en,
  output logic        waiting_for_trig,
  output logic        halt,
  output frame_req_t  frame_req,
  output err_flags_t  err_flags
);

  localparam frame_idx_t LAST_FRAME = frame_idx_t'(`ADS_RD_FRAMES - 1);

  acq_state_e state;
  acq_state_e take_state; // Where the head command leads
  logic       trig_q;     // Running command ends on a trigger
  logic       cont_q;     // Running command needs a successor
  delay_t     delay_cnt;
  frame_idx_t frame_idx;
  logic       start_q;
  logic       head_valid;
  logic       has_tail;   // NO_OP or ADC_RD at the head
  logic       cmd_end;    // Delay expired or trigger seen
  logic       cancel;
  logic       take;
  logic       rd_done;    // Flush frame finished
  logic       unexp_ev;
  logic       underflow_ev;
  logic       halt_ev;

  //////////////////////////////
  // Command flow
  //////////////////////////////
  assign head_valid = !cmd_buf_empty;
  assign has_tail   = cmd.kind == CMD_NO_OP || cmd.kind == CMD_ADC_RD;
  assign cmd_end    = (state == ST_DELAY && delay_cnt == '0) ||
                      (state == ST_TRIG_WAIT && trigger);
  // CANCEL jumps the queue only while waiting
  assign cancel     = (state == ST_DELAY || state == ST_TRIG_WAIT) &&
                      head_valid && cmd.kind == CMD_CANCEL;
  assign rd_done    = state == ST_ADC_RD && frame_done && frame_idx == LAST_FRAME;

  assign unexp_ev     = trigger && state != ST_TRIG_WAIT && state != ST_HALT;
  assign underflow_ev = cmd_end && cont_q && !head_valid; // Promised successor missing
  assign halt_ev      = unexp_ev || underflow_ev || overflow;

  // No pop in the cycle an error fires
  assign take           = head_valid && !halt_ev && (state == ST_IDLE || cmd_end || cancel);
  assign cmd_word_rd_en = take;

  always_comb begin
    case (cmd.kind)
      CMD_NO_OP:  take_state = cmd.trig ? ST_TRIG_WAIT : ST_DELAY;
      CMD_ADC_RD: take_state = ST_ADC_RD;
      default:    take_state = ST_IDLE; // SET_ORD and CANCEL finish at once
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= ST_IDLE;
    end else if (halt_ev) begin
      state <= ST_HALT;
    end else if (take) begin
      state <= take_state;
    end else if (cmd_end) begin
      state <= ST_IDLE; // Queue empty and nothing promised
    end else if (rd_done) begin
      state <= trig_q ? ST_TRIG_WAIT : ST_DELAY; // Read tail
    end
  end

  assign halt             = state == ST_HALT;
  assign waiting_for_trig = state == ST_TRIG_WAIT;

  // Trig and cont bits of the running command
  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      trig_q <= 1'b0;
      cont_q <= 1'b0;
    end else if (take) begin
      trig_q <= has_tail && cmd.trig;
      cont_q <= has_tail && cmd.cont;
    end
  end

  // Delay runs from the take so an ADC_RD delay sets the sample period
  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      delay_cnt <= '0;
    end else if (take && has_tail && !cmd.trig) begin
      delay_cnt <= cmd.delay;
    end else if (cancel) begin
      delay_cnt <= '0;
    end else if (delay_cnt != '0) begin
      delay_cnt <= delay_cnt - 1'b1;
    end
  end

  //////////////////////////////
  // Frame sequencing
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      frame_idx <= '0;
      start_q   <= 1'b0;
    end else begin
      start_q <= 1'b0;
      if (take && cmd.kind == CMD_ADC_RD) begin
        frame_idx <= '0;
        start_q   <= 1'b1;
      end else if (state == ST_ADC_RD && frame_done && frame_idx != LAST_FRAME) begin
        frame_idx <= frame_idx + 1'b1;
        start_q   <= 1'b1; // Next frame right after frame_done
      end
    end
  end

  always_comb begin
    frame_req.start   = start_q;
    frame_req.chan    = (frame_idx == LAST_FRAME) ? chan_t'(0) // Flush frame
                                                  : order[frame_idx[$bits(chan_t)-1:0]];
    frame_req.capture = frame_idx != '0; // Result lags its request by one frame
  end

  //////////////////////////////
  // Sticky errors
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!resetn) begin
      err_flags <= '0;
    end else begin
      if (unexp_ev)     err_flags.unexp_trig        <= 1'b1;
      if (underflow_ev) err_flags.cmd_buf_underflow <= 1'b1;
      if (overflow)     err_flags.data_buf_overflow <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "ads816x_params.svh"

// Head command word split into fields, plus the channel order table
module cmd_decoder
  import ads816x_pkg::*;
(
  input  wire            clk,
  input  wire            resetn,
  input  wire cmd_word_t cmd_word, // Head of the FWFT command buffer
  input  wire            take,     // Head popped this cycle
  output cmd_t           cmd,
  output order_t         order     // Active channel order
);

  //////////////////////////////
  // Field split
  //////////////////////////////
  always_comb begin
    cmd.kind        = cmd_kind_e'(cmd_word[`CMD_KIND_MSB:`CMD_KIND_LSB]);
    cmd.trig        = cmd_word[`CMD_TRIG_BIT];
    cmd.cont        = cmd_word[`CMD_CONT_BIT];
    cmd.delay       = cmd_word[$bits(delay_t)-1:0]; // Only meaningful for NO_OP/ADC_RD
    cmd.order_field = cmd_word[$bits(order_t)-1:0]; // Only meaningful for SET_ORD
  end

  //////////////////////////////
  // Channel order
  //////////////////////////////
  // Identity order after reset
  // A taken SET_ORD replaces all eight slots at once
  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < `ADS_NUM_CH; i++) begin
        order[i] <= chan_t'(i);
      end
    end else if (take && cmd.kind == CMD_SET_ORD) begin
      order <= cmd.order_field;
    end
  end

endmodule

`default_nettype wire

//--- rtl/ads816x_pkg.sv
`default_nettype none
`include "ads816x_params.svh"

package ads816x_pkg;

  // Vectors with a meaning of their own
  typedef logic [31:0] cmd_word_t;             // Raw command or data word
  typedef logic [15:0] sample_t;               // One ADC result
  typedef logic [2:0]  chan_t;                 // Channel number
  typedef logic [25:0] delay_t;                // Delay in clk cycles
  typedef chan_t [`ADS_NUM_CH-1:0] order_t;    // Slot 0 in the low bits
  typedef logic [3:0]  frame_idx_t;            // Frame within one read

  // Command kinds from the top two bits
  typedef enum logic [1:0] {
    CMD_NO_OP   = 2'd0, // Delay or trigger wait
    CMD_ADC_RD  = 2'd1, // Read all channels
    CMD_SET_ORD = 2'd2, // Load a channel order
    CMD_CANCEL  = 2'd3  // Abort a wait
  } cmd_kind_e;

  // Sequencer states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_DELAY,
    ST_TRIG_WAIT,
    ST_ADC_RD,
    ST_HALT     // Sticky until reset
  } acq_state_e;

  typedef struct packed {
    cmd_kind_e kind;
    logic      trig;        // Wait for trigger instead of a delay
    logic      cont;        // A further command must be queued
    delay_t    delay;
    order_t    order_field;
  } cmd_t;

  typedef struct packed {
    logic  start;   // One-cycle frame start
    chan_t chan;    // Channel requested in this frame
    logic  capture; // Frame returns a result
  } frame_req_t;

  typedef struct packed {
    logic unexp_trig;
    logic cmd_buf_underflow;
    logic data_buf_overflow;
  } err_flags_t;

endpackage

`default_nettype wire

//--- rtl/ads816x_params.svh
`ifndef ADS816X_PARAMS_SVH
`define ADS816X_PARAMS_SVH

//////////////////////////////
// ADC model and SPI timing
//////////////////////////////
`define ADS_MODEL_ID 8 // 8 for ADS8168, 7 for ADS8167, 6 for ADS8166

// Minimum n_cs high time in clk cycles at a 20 MHz SPI clock
`define ADS_CS_HIGH_CYCLES ((`ADS_MODEL_ID == 8) ? 14 : (`ADS_MODEL_ID == 7) ? 24 : 50)

`define ADS_FRAME_BITS 16 // On-the-fly request length
`define ADS_NUM_CH     8  // Channels per read
`define ADS_RD_FRAMES  9  // Eight requests plus one flush frame

//////////////////////////////
// Command word fields
//////////////////////////////
`define CMD_KIND_MSB 31
`define CMD_KIND_LSB 30
`define CMD_TRIG_BIT 29
`define CMD_CONT_BIT 28

`endif
